/* hdl/mem_pkg.sv */
package mem_pkg;

   // memory geometry
   localparam int MEM_AW    = 10;            // word address width
   localparam int MEM_WORDS = 2 ** MEM_AW;   // 1024 words

   // data words, instructions and byte addresses
   typedef logic [31:0] word_t;

   // word index into the memory array
   typedef logic [MEM_AW-1:0] word_addr_t;

   // one enable per byte lane, lane 0 is the lsb (little-endian)
   typedef logic [3:0] byte_en_t;

   // access size on the load/store port
   typedef logic [1:0] acc_size_t;

   // size codes
   localparam acc_size_t SIZE_BYTE = 2'd0;   // lb / lbu / sb
   localparam acc_size_t SIZE_HALF = 2'd1;   // lh / lhu / sh
   localparam acc_size_t SIZE_WORD = 2'd2;   // lw / sw

   // 2'd3 is not a legal size
   // the datapath handles it like a word access

endpackage : mem_pkg

/* hdl/lsu_align.sv */
`timescale 1ns/1ps

module lsu_align import mem_pkg::*; (
   input  logic       mem_read,     // load strobe
   input  logic       mem_write,    // store strobe
   input  acc_size_t  size,
   input  logic       unsigned_ld,  // lbu / lhu
   input  word_t      addr,         // byte address
   input  word_t      wdata,        // narrow data sits in the lsbs
   input  word_t      mem_rdata,    // raw word from memory
   output word_addr_t word_addr,
   output byte_en_t   be_req,       // requested lanes, before the guard
   output word_t      lane_wdata,
   output word_t      rdata,        // extended load result
   output logic       misaligned
);

   logic     mis_raw;     // alignment fault, not yet qualified by the strobes
   logic     active;      // a load or store this cycle
   logic [4:0] lane_sh;   // bit offset of the addressed lane
   word_t    lane_word;   // memory word shifted down to lane 0
   logic     sign_bit;

   assign word_addr = addr[MEM_AW+1:2];  // drop the byte offset
   assign lane_sh   = {addr[1:0], 3'b000};
   assign active    = mem_read | mem_write;

   // alignment check
   always_comb begin
      case (size)
         SIZE_BYTE: mis_raw = 1'b0;                  // bytes always fit
         SIZE_HALF: mis_raw = addr[0];
         default:   mis_raw = addr[1] | addr[0];     // word, and illegal 2'd3
      endcase
   end

   assign misaligned = active & mis_raw;

   // store side, lane enables
   always_comb begin
      be_req = '0;
      if (mem_write && !mis_raw) begin
         case (size)
            SIZE_BYTE: be_req = 4'b0001 << addr[1:0];
            SIZE_HALF: be_req = 4'b0011 << addr[1:0];  // addr[0] is 0 here
            default:   be_req = 4'b1111;
         endcase
      end
   end

   // move lsb data up into the addressed lanes
   assign lane_wdata = wdata << lane_sh;  // zero shift for an aligned word

   // load side
   assign lane_word = mem_rdata >> lane_sh;

   always_comb begin
      sign_bit = 1'b0;
      rdata    = '0;  // idle or misaligned load returns 0
      if (mem_read && !mis_raw) begin
         case (size)
            SIZE_BYTE: begin
               sign_bit = ~unsigned_ld & lane_word[7];
               rdata    = {{24{sign_bit}}, lane_word[7:0]};
            end
            SIZE_HALF: begin
               sign_bit = ~unsigned_ld & lane_word[15];
               rdata    = {{16{sign_bit}}, lane_word[15:0]};
            end
            default: begin
               rdata = mem_rdata;  // full word, nothing to extend
            end
         endcase
      end
   end

endmodule : lsu_align

/* hdl/unified_mem.sv */
`timescale 1ns/1ps

module unified_mem import mem_pkg::*; (
   input  logic       clk,
   input  word_addr_t word_addr,   // data side word index
   input  byte_en_t   be_wr,       // gated lane enables, zero when no store
   input  word_t      lane_wdata,  // data already in its lanes
   output word_t      mem_rdata,   // raw word, extension happens in the lsu
   input  word_t      pc,          // fetch byte address
   output word_t      instr
);

   // four byte lanes per word, lane 0 is the lsb
   logic [3:0][7:0] mem [MEM_WORDS];

   word_addr_t fetch_addr;

   assign fetch_addr = pc[MEM_AW+1:2];  // pc is word aligned, low bits ignored

   // instruction fetch, asynchronous
   assign instr = mem[fetch_addr];

   // data read, asynchronous
   // new data is visible the cycle after the write edge
   assign mem_rdata = mem[word_addr];

   // byte-enabled write
   // contents start unknown, nothing to clear here
   always_ff @(posedge clk) begin
      for (int i = 0; i < 4; i++) begin
         if (be_wr[i]) begin
            mem[word_addr][i] <= lane_wdata[8*i +: 8];  // one lane per enable
         end
      end
   end

endmodule : unified_mem

/* hdl/mem_guard_regs.sv */
`timescale 1ns/1ps

module mem_guard_regs import mem_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       cfg_we,      // load a new limit, clear status
   input  word_addr_t cfg_limit,   // first writable word
   input  word_addr_t word_addr,   // store target
   input  byte_en_t   be_req,      // nonzero only on a legal store
   input  word_t      addr,        // byte address, kept for the fault report
   output byte_en_t   be_wr,       // enables that reach the memory
   output logic       violation,   // sticky
   output word_t      fault_addr   // first blocked store
);

   word_addr_t limit_q;
   logic       store_req;
   logic       below_limit;
   logic       blocked;

   assign store_req   = |be_req;
   assign below_limit = word_addr < limit_q;  // limit 0 protects nothing
   assign blocked     = store_req & below_limit;

   // kill every lane of a blocked store
   assign be_wr = blocked ? '0 : be_req;

   // protection limit
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         limit_q <= '0;
      end else if (cfg_we) begin
         limit_q <= cfg_limit;
      end
   end

   // status, cfg_we takes priority over a blocked store
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         violation  <= 1'b0;
         fault_addr <= '0;
      end else if (cfg_we) begin
         violation  <= 1'b0;  // clear on reconfig
         fault_addr <= '0;
      end else if (blocked) begin
         violation <= 1'b1;
         if (!violation) begin
            fault_addr <= addr;  // only the first one is kept
         end
      end
   end

endmodule : mem_guard_regs

/* hdl/mem_subsys_top.sv */
`timescale 1ns/1ps

module mem_subsys_top import mem_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   // fetch
   input  word_t      pc,
   output word_t      instr,
   // data port
   input  logic       mem_read,
   input  logic       mem_write,
   input  acc_size_t  size,
   input  logic       unsigned_ld,
   input  word_t      addr,
   input  word_t      wdata,
   output word_t      rdata,
   output logic       misaligned,
   // protection config
   input  logic       cfg_we,
   input  word_addr_t cfg_limit,
   // status
   output logic       violation,
   output word_t      fault_addr
);

   word_addr_t word_addr;   // lsu -> guard, memory
   byte_en_t   be_req;      // lsu -> guard
   byte_en_t   be_wr;       // guard -> memory
   word_t      lane_wdata;  // lsu -> memory
   word_t      mem_rdata;   // memory -> lsu

   lsu_align u_lsu (
      .mem_read    (mem_read),
      .mem_write   (mem_write),
      .size        (size),
      .unsigned_ld (unsigned_ld),
      .addr        (addr),
      .wdata       (wdata),
      .mem_rdata   (mem_rdata),
      .word_addr   (word_addr),
      .be_req      (be_req),
      .lane_wdata  (lane_wdata),
      .rdata       (rdata),
      .misaligned  (misaligned)
   );

   mem_guard_regs u_guard (
      .clk        (clk),
      .rst_n      (rst_n),
      .cfg_we     (cfg_we),
      .cfg_limit  (cfg_limit),
      .word_addr  (word_addr),
      .be_req     (be_req),
      .addr       (addr),
      .be_wr      (be_wr),
      .violation  (violation),
      .fault_addr (fault_addr)
   );

   unified_mem u_mem (
      .clk        (clk),
      .word_addr  (word_addr),
      .be_wr      (be_wr),
      .lane_wdata (lane_wdata),
      .mem_rdata  (mem_rdata),
      .pc         (pc),         // fetch bypasses the lsu
      .instr      (instr)
   );

endmodule : mem_subsys_top

/* dv/mem_subsys_sva.sv */
`timescale 1ns/1ps

module mem_subsys_sva import mem_pkg::*; (
   input logic     clk,
   input logic     rst_n,
   input logic     mem_read,
   input logic     mem_write,
   input logic     misaligned,
   input byte_en_t be_wr,       // guard output, internal to the top
   input logic     violation,
   input logic     cfg_we
);

   // only a real access can be misaligned
   mis_needs_strobe: assert property (
      @(posedge clk) disable iff (!rst_n)
      misaligned |-> (mem_read || mem_write)
   ) else $error("misaligned set with both strobes low");

   // no lane reaches the memory on a misaligned access
   mis_blocks_write: assert property (
      @(posedge clk) disable iff (!rst_n)
      misaligned |-> (be_wr == '0)
   ) else $error("byte enables active on a misaligned access");

   // sticky flag, falls only after a config write
   viol_sticky: assert property (
      @(posedge clk) disable iff (!rst_n)
      $fell(violation) |-> $past(cfg_we)
   ) else $error("violation cleared without cfg_we");

endmodule : mem_subsys_sva

bind mem_subsys_top mem_subsys_sva sva0 (
   .clk        (clk),
   .rst_n      (rst_n),
   .mem_read   (mem_read),
   .mem_write  (mem_write),
   .misaligned (misaligned),
   .be_wr      (be_wr),
   .violation  (violation),
   .cfg_we     (cfg_we)
);

/* dv/tb_mem_subsys.sv */
`timescale 1ns/1ps

module tb_mem_subsys import mem_pkg::*; ();

   localparam int WIN_AW    = 8;              // test window, 256 words
   localparam int WIN_WORDS = 2 ** WIN_AW;
   localparam int N_WORD    = 64;
   localparam int N_NARROW  = 64;
   localparam int N_MIS     = 32;
   localparam int N_PROT    = 32;
   localparam int N_CLR     = 16;
   // reset + fill + tests 1..6, one access per cycle
   localparam int TEST_CYCLES = 6 + WIN_WORDS + 3 + 2*N_WORD + 3*N_NARROW + 4*N_MIS
                              + 1 + 4*N_PROT + 2 + 2*N_CLR;
   localparam int MAX_CYCLES  = 2 * TEST_CYCLES;

   logic       clk;
   logic       rst_n;
   word_t      pc;
   word_t      instr;
   logic       mem_read;
   logic       mem_write;
   acc_size_t  size;
   logic       unsigned_ld;
   word_t      addr;
   word_t      wdata;
   word_t      rdata;
   logic       misaligned;
   logic       cfg_we;
   word_addr_t cfg_limit;
   logic       violation;
   word_t      fault_addr;

   logic [7:0] shadow [4*WIN_WORDS];  // expected memory bytes, window only
   word_addr_t limit_m;
   logic       viol_m;
   word_t      fault_m;
   logic       chk_en;                // compare this cycle
   word_t      exp_rdata;
   word_t      exp_instr;
   word_t      exp_fault;
   logic       exp_mis;
   logic       exp_viol;
   int         err_cnt;
   int         chk_cnt;
   int         cyc_cnt;
   int         test_err0;
   int         n_tests;
   integer     seed;

   mem_subsys_top dut0 (
      .clk         (clk),
      .rst_n       (rst_n),
      .pc          (pc),
      .instr       (instr),
      .mem_read    (mem_read),
      .mem_write   (mem_write),
      .size        (size),
      .unsigned_ld (unsigned_ld),
      .addr        (addr),
      .wdata       (wdata),
      .rdata       (rdata),
      .misaligned  (misaligned),
      .cfg_we      (cfg_we),
      .cfg_limit   (cfg_limit),
      .violation   (violation),
      .fault_addr  (fault_addr)
   );

   always #10 clk = ~clk;  // 20 ns period

   // halfwords need an even address, words a multiple of four
   function automatic logic is_mis(acc_size_t sz, word_t a);
      if (sz == SIZE_BYTE) return 1'b0;
      if (sz == SIZE_HALF) return a[0];
      return a[1:0] != 2'b00;
   endfunction

   // expected load result, built from the shadow bytes
   function automatic word_t exp_load(acc_size_t sz, word_t a, logic uns);
      logic [WIN_AW+1:0] i;
      word_t             w;
      i = a[WIN_AW+1:0];
      if (is_mis(sz, a)) return '0;
      case (sz)
         SIZE_BYTE: begin
            w = {24'h0, shadow[i]};
            if (!uns && shadow[i][7]) w[31:8] = '1;   // sign fill
         end
         SIZE_HALF: begin
            w = {16'h0, shadow[{i[WIN_AW+1:1], 1'b1}], shadow[i]};
            if (!uns && shadow[{i[WIN_AW+1:1], 1'b1}][7]) w[31:16] = '1;
         end
         default: w = {shadow[{i[WIN_AW+1:2], 2'd3}], shadow[{i[WIN_AW+1:2], 2'd2}],
                       shadow[{i[WIN_AW+1:2], 2'd1}], shadow[i]};
      endcase
      return w;
   endfunction

   // aligned byte address for sz within words lo..hi-1
   function automatic word_t rand_addr(acc_size_t sz, int lo, int hi);
      word_t a;
      a = word_t'(lo + ($unsigned($random(seed)) % (hi - lo))) << 2;
      if (sz == SIZE_BYTE) a[1:0] = 2'($random(seed));
      else if (sz == SIZE_HALF) a[1] = 1'($random(seed));
      return a;
   endfunction

   task automatic write_shadow(acc_size_t sz, word_t a, word_t d);
      logic [WIN_AW+1:0] i;
      i = a[WIN_AW+1:0];
      shadow[i] = d[7:0];                              // lsb lane first
      if (sz != SIZE_BYTE) shadow[{i[WIN_AW+1:1], 1'b1}] = d[15:8];
      if (sz == SIZE_WORD) begin
         shadow[{i[WIN_AW+1:2], 2'd2}] = d[23:16];
         shadow[{i[WIN_AW+1:2], 2'd3}] = d[31:24];
      end
   endtask

   // one access per cycle, model follows the dut at the rising edge
   task automatic run_cycle(input logic rd, input logic wr, input acc_size_t sz,
                            input logic uns, input word_t a, input word_t d,
                            input logic cfg, input word_addr_t lim, input logic chk);
      logic blocked;
      @(negedge clk);
      mem_read    = rd;
      mem_write   = wr;
      size        = sz;
      unsigned_ld = uns;
      addr        = a;
      wdata       = d;
      pc          = (rd | wr) ? a : rand_addr(SIZE_WORD, 0, WIN_WORDS);  // idle fetches elsewhere
      cfg_we      = cfg;
      cfg_limit   = lim;
      exp_rdata   = rd ? exp_load(sz, a, uns) : '0;
      exp_instr   = exp_load(SIZE_WORD, {pc[31:2], 2'b00}, 1'b0);
      exp_mis     = (rd | wr) & is_mis(sz, a);
      exp_viol    = viol_m;
      exp_fault   = fault_m;
      chk_en      = chk;
      @(posedge clk);
      blocked = wr && !is_mis(sz, a) && (a[MEM_AW+1:2] < limit_m);  // old limit
      if (cfg) begin
         limit_m = lim;     // config write wins over a blocked store
         viol_m  = 1'b0;
         fault_m = '0;
      end else if (blocked) begin
         if (!viol_m) fault_m = a;
         viol_m = 1'b1;
      end
      if (wr && !is_mis(sz, a) && !blocked) write_shadow(sz, a, d);
   endtask

   task automatic store_data(acc_size_t sz, word_t a, word_t d);
      run_cycle(1'b0, 1'b1, sz, 1'b0, a, d, 1'b0, '0, 1'b1);
   endtask

   task automatic load_data(acc_size_t sz, word_t a, logic uns);
      run_cycle(1'b1, 1'b0, sz, uns, a, '0, 1'b0, '0, 1'b1);
   endtask

   task automatic set_limit(word_addr_t lim);
      run_cycle(1'b0, 1'b0, SIZE_WORD, 1'b0, '0, '0, 1'b1, lim, 1'b1);
   endtask

   task automatic idle_cycle();
      run_cycle(1'b0, 1'b0, SIZE_WORD, 1'b0, '0, '0, 1'b0, '0, 1'b1);
   endtask

   task automatic report_test(string name);
      n_tests++;
      $display("test %0d %s finished, %0d errors", n_tests, name, err_cnt - test_err0);
      test_err0 = err_cnt;
   endtask

   // compare in the low phase, inputs settled since the falling edge
   always begin
      @(negedge clk);
      #5;
      if (chk_en) begin
         chk_cnt++;
         if (rdata !== exp_rdata) begin
            $display("[ERROR] %0t rdata: expected %h, got %h", $time, exp_rdata, rdata);
            err_cnt++;
         end
         if (instr !== exp_instr) begin
            $display("[ERROR] %0t instr: expected %h, got %h", $time, exp_instr, instr);
            err_cnt++;
         end
         if (misaligned !== exp_mis) begin
            $display("[ERROR] %0t misaligned: expected %b, got %b", $time, exp_mis, misaligned);
            err_cnt++;
         end
         if (violation !== exp_viol) begin
            $display("[ERROR] %0t violation: expected %b, got %b", $time, exp_viol, violation);
            err_cnt++;
         end
         if (fault_addr !== exp_fault) begin
            $display("[ERROR] %0t fault_addr: expected %h, got %h", $time, exp_fault,
                     fault_addr);
            err_cnt++;
         end
      end
   end

   always @(posedge clk) begin
      cyc_cnt++;
      if (cyc_cnt > MAX_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("Errors found");
         $finish;
      end
   end

   initial begin
      word_t      a;
      acc_size_t  sz;
      word_addr_t lim;
      seed        = 32'h5612_38e3;
      clk         = 1'b0;
      rst_n       = 1'b0;
      pc          = '0;
      mem_read    = 1'b0;
      mem_write   = 1'b0;
      size        = SIZE_WORD;
      unsigned_ld = 1'b0;
      addr        = '0;
      wdata       = '0;
      cfg_we      = 1'b0;
      cfg_limit   = '0;
      limit_m     = '0;
      viol_m      = 1'b0;
      fault_m     = '0;
      chk_en      = 1'b0;
      err_cnt     = 0;
      chk_cnt     = 0;
      cyc_cnt     = 0;
      n_tests     = 0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      // window fill, memory starts unknown
      for (int w = 0; w < WIN_WORDS; w++) begin
         run_cycle(1'b0, 1'b1, SIZE_WORD, 1'b0, word_t'(w) << 2,
                   (word_t'(w) * 32'h0001_0003) ^ 32'h5A3C_96E1, 1'b0, '0, 1'b0);
      end
      test_err0 = err_cnt;

      idle_cycle();                                 // status still clear
      store_data(SIZE_WORD, 32'h0, 32'hdead_beef);  // limit 0, lands
      load_data(SIZE_WORD, 32'h0, 1'b0);
      report_test("reset state");

      for (int n = 0; n < N_WORD; n++) begin
         a = rand_addr(SIZE_WORD, 0, WIN_WORDS);
         store_data(SIZE_WORD, a, word_t'($random(seed)));
         load_data(SIZE_WORD, a, 1'b0);             // instr checked at the same pc
      end
      report_test("word path");

      for (int n = 0; n < N_NARROW; n++) begin
         sz = ($random(seed) & 1) ? SIZE_HALF : SIZE_BYTE;
         a  = rand_addr(sz, 0, WIN_WORDS);
         store_data(sz, a, word_t'($random(seed)));
         load_data(SIZE_WORD, {a[31:2], 2'b00}, 1'b0);  // other lanes untouched
         sz = ($random(seed) & 1) ? SIZE_HALF : SIZE_BYTE;
         load_data(sz, rand_addr(sz, 0, WIN_WORDS), 1'($random(seed)));
      end
      report_test("narrow access");

      for (int n = 0; n < N_MIS; n++) begin
         sz = ($random(seed) & 1) ? SIZE_HALF : SIZE_WORD;
         a  = rand_addr(SIZE_BYTE, 0, WIN_WORDS);
         if (sz == SIZE_HALF) a[0] = 1'b1;
         else if (a[1:0] == 2'b00) a[1:0] = 2'b11;
         load_data(sz, a, 1'b0);
         store_data(sz, a, word_t'($random(seed)));     // dropped
         load_data(SIZE_WORD, {a[31:2], 2'b00}, 1'b0);
         run_cycle(1'b0, 1'b0, sz, 1'b0, a, '0, 1'b0, '0, 1'b1);  // strobes low, no flag
      end
      report_test("misalignment");

      lim = word_addr_t'(16 + ($unsigned($random(seed)) % (WIN_WORDS - 32)));
      set_limit(lim);
      for (int n = 0; n < N_PROT; n++) begin
         sz = acc_size_t'($unsigned($random(seed)) % 3);
         a  = rand_addr(sz, 0, int'(lim));             // below the limit
         store_data(sz, a, word_t'($random(seed)));
         load_data(SIZE_WORD, {a[31:2], 2'b00}, 1'b0);
      end
      for (int n = 0; n < N_PROT; n++) begin
         sz = acc_size_t'($unsigned($random(seed)) % 3);
         a  = rand_addr(sz, int'(lim), WIN_WORDS);
         store_data(sz, a, word_t'($random(seed)));
         load_data(SIZE_WORD, {a[31:2], 2'b00}, 1'b0);
      end
      report_test("protection");

      // clear together with one more blocked store, cfg_we wins
      a = rand_addr(SIZE_WORD, 0, int'(lim));
      run_cycle(1'b0, 1'b1, SIZE_WORD, 1'b0, a, 32'hbad0_0bad, 1'b1, '0, 1'b1);
      idle_cycle();
      for (int n = 0; n < N_CLR; n++) begin
         a = rand_addr(SIZE_WORD, 0, int'(lim));      // was protected
         store_data(SIZE_WORD, a, word_t'($random(seed)));
         load_data(SIZE_WORD, a, 1'b0);
      end
      report_test("clearing");

      $display("summary: %0d tests, %0d checks, %0d errors", n_tests, chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule : tb_mem_subsys

/* all.f */
hdl/mem_pkg.sv
hdl/lsu_align.sv
hdl/unified_mem.sv
hdl/mem_guard_regs.sv
hdl/mem_subsys_top.sv
dv/mem_subsys_sva.sv
dv/tb_mem_subsys.sv

/* Makefile */
SIM := obj_dir/Vtb_mem_subsys

.PHONY: all run clean

all: run

$(SIM): all.f $(wildcard hdl/*.sv) $(wildcard dv/*.sv)
	verilator --binary --timing --assert --top-module tb_mem_subsys -f all.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log
